// File: filelist.f
+incdir+include
verilog/lite_xbar_pkg.sv
verilog/lite_slice.sv
verilog/lite_addr_decode.sv
verilog/lite_slave_mux.sv
verilog/lite_resp_route.sv
verilog/lite_xbar.sv
verif/lite_xbar_sva.sv
verif/lite_xbar_tb.sv

// File: include/lite_xbar_macros.svh
/*
 * Size definitions of the lite crossbar. Included by the package and by every
 * module that sizes ports or arrays over masters and slaves.
 */
`ifndef LITE_XBAR_MACROS_SVH
`define LITE_XBAR_MACROS_SVH

// Bus widths.
`define LITE_ADDR_W 32
`define LITE_DATA_W 32
`define LITE_STRB_W (`LITE_DATA_W / 8)

// Port counts on each side of the crossbar.
`define LITE_NUM_MST 2
`define LITE_NUM_SLV 2

// The region index starts at this address bit.
// Slave i owns the addresses whose top nibble is i.
`define LITE_SLV_SHIFT 28

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the crossbar testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lite_xbar_tb \
  -f filelist.f -o sim_lite_xbar

./obj_dir/sim_lite_xbar | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
  exit 0
fi
exit 1

// File: verif/lite_xbar_input.txt
// master op(1=write) addr wdata strb expected_rdata expected_resp(0=OKAY 3=DECERR)
// Unwritten words read back their own byte address.
0 1 00000010 11223344 f 00000000 0
1 1 00000020 55667788 f 00000000 0
0 0 00000010 00000000 0 11223344 0
1 0 00000020 00000000 0 55667788 0
0 1 10000020 aabbccdd 3 00000000 0
1 1 00000048 cafef00d 9 00000000 0
0 0 10000020 00000000 0 1000ccdd 0
1 0 00000048 00000000 0 ca00000d 0
0 0 20000000 00000000 0 00000000 3
1 1 10000030 01020304 c 00000000 0
0 1 f0000004 deadbeef f 00000000 3
1 0 10000030 00000000 0 01020030 0
0 0 00000040 00000000 0 00000040 0
1 0 30000000 00000000 0 00000000 3
0 0 10000044 00000000 0 10000044 0
1 0 10000048 00000000 0 10000048 0

// File: verif/lite_xbar_sva.sv
/*
 * Assertions bound into the crossbar top level. They check payload stability
 * on the DUT-driven channels, one granted request in flight per slave, and
 * that a master only sees a response while its decoder is busy.
 */
`timescale 1ns/10ps
`default_nettype none

`include "lite_xbar_macros.svh"

module lite_xbar_sva (
  input logic                     clk,
  input logic                     arst_n,
  input logic [`LITE_NUM_SLV-1:0] slv_req_valid,
  input logic [`LITE_NUM_SLV-1:0] slv_req_ready,
  input logic [`LITE_ADDR_W-1:0]  slv_req_addr [`LITE_NUM_SLV],
  input logic [`LITE_DATA_W-1:0]  slv_req_wdata [`LITE_NUM_SLV],
  input logic [`LITE_NUM_SLV-1:0] slv_rsp_valid,
  input logic [`LITE_NUM_SLV-1:0] slv_rsp_ready,
  input logic [`LITE_NUM_MST-1:0] mst_rsp_valid,
  input logic [`LITE_NUM_MST-1:0] mst_rsp_ready,
  input logic [`LITE_DATA_W-1:0]  mst_rsp_rdata [`LITE_NUM_MST],
  input logic [`LITE_NUM_MST-1:0] busy
);

  logic [`LITE_NUM_SLV-1:0] in_flight;

  // Set when a request reaches the slave, cleared when its response is taken.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      in_flight <= '0;
    end else begin
      in_flight <= (in_flight & ~(slv_rsp_valid & slv_rsp_ready)) |
                   (slv_req_valid & slv_req_ready);
    end
  end

  for (genvar j = 0; j < `LITE_NUM_SLV; j++) begin : g_slv
    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
      slv_req_valid[j] && !slv_req_ready[j] |=>
        slv_req_valid[j] && $stable(slv_req_addr[j]) && $stable(slv_req_wdata[j]))
      else $error("slave %0d request changed while waiting", j);
    a_one_grant: assert property (@(posedge clk) disable iff (!arst_n)
      in_flight[j] |-> !slv_req_valid[j])
      else $error("slave %0d offered a second request before its response", j);
  end

  for (genvar m = 0; m < `LITE_NUM_MST; m++) begin : g_mst
    a_rsp_stable: assert property (@(posedge clk) disable iff (!arst_n)
      mst_rsp_valid[m] && !mst_rsp_ready[m] |=>
        mst_rsp_valid[m] && $stable(mst_rsp_rdata[m]))
      else $error("master %0d response changed while waiting", m);
    a_rsp_owned: assert property (@(posedge clk) disable iff (!arst_n)
      mst_rsp_valid[m] |-> busy[m])
      else $error("master %0d response without a request in flight", m);
  end

endmodule

bind lite_xbar lite_xbar_sva u_sva (
  .clk           (clk),
  .arst_n        (arst_n),
  .slv_req_valid (slv_req_valid),
  .slv_req_ready (slv_req_ready),
  .slv_req_addr  (slv_req_addr),
  .slv_req_wdata (slv_req_wdata),
  .slv_rsp_valid (slv_rsp_valid),
  .slv_rsp_ready (slv_rsp_ready),
  .mst_rsp_valid (mst_rsp_valid),
  .mst_rsp_ready (mst_rsp_ready),
  .mst_rsp_rdata (mst_rsp_rdata),
  .busy          ({g_mst[1].u_dec.busy, g_mst[0].u_dec.busy})
);

`default_nettype wire

// File: verif/lite_xbar_tb.sv
/*
 * Testbench of the lite crossbar. Two master state machines replay the
 * transactions of the input data file, and two slave models answer from
 * byte-strobed memories with random ready and delay. Each response is
 * checked against the expected read data and code given in the file.
 */
`timescale 1ns/10ps
`default_nettype none

`include "lite_xbar_macros.svh"

module lite_xbar_tb;

  localparam int MAX_LINES = 64;
  localparam int COLS = 7;

  logic clk = 1'b0;
  logic arst_n;
  logic [1:0] mst_req_valid, mst_req_ready, mst_req_write, mst_rsp_valid, mst_rsp_ready;
  logic [31:0] mst_req_addr [2];
  logic [31:0] mst_req_wdata [2];
  logic [3:0] mst_req_strb [2];
  logic [31:0] mst_rsp_rdata [2];
  lite_xbar_pkg::resp_e mst_rsp_resp [2];
  logic [1:0] slv_req_valid, slv_req_ready, slv_req_write, slv_rsp_valid, slv_rsp_ready;
  logic [31:0] slv_req_addr [2];
  logic [31:0] slv_req_wdata [2];
  logic [3:0] slv_req_strb [2];
  logic [31:0] slv_rsp_rdata [2];
  lite_xbar_pkg::resp_e slv_rsp_resp [2];

  logic [31:0] vec [0:MAX_LINES*COLS-1];
  logic [31:0] smem [2][256];
  int mst_q [2][$];
  int nlines, mapped, limit, cycles, errors, passed, failed, done_cnt, sreq_cnt;
  int mstate [2];
  int cur [2];
  int sstate [2];
  int sdelay [2];
  logic [31:0] srdata [2];
  logic [1:0] mreq_x, mrsp_x, sreq_x, srsp_x;
  logic [31:0] cap_rdata [2];
  logic [1:0] cap_resp [2];
  logic [31:0] cap_addr [2];
  logic [31:0] cap_wdata [2];
  logic [3:0] cap_strb [2];
  logic [1:0] cap_write;

  always #2 clk = !clk;

  lite_xbar uut (.*);

  // Compare one finished response with the file and report the test.
  task automatic check_response(input int m);
    int b;
    logic ok;
    b  = cur[m] * COLS;
    ok = 1'b1;
    if (cap_rdata[m] !== vec[b+5]) begin
      $display("ERROR %0t: line %0d master %0d rdata %h, expected %h",
               $time, cur[m], m, cap_rdata[m], vec[b+5]);
      ok = 1'b0;
    end
    if (cap_resp[m] !== vec[b+6][1:0]) begin
      $display("ERROR %0t: line %0d master %0d resp %0d, expected %0d",
               $time, cur[m], m, cap_resp[m], vec[b+6][1:0]);
      ok = 1'b0;
    end
    if (ok) passed++;
    else begin
      failed++;
      errors++;
    end
    $display("test %0d master %0d addr %h %s", cur[m], m, vec[b+2], ok ? "ok" : "FAILED");
  endtask

  // Byte-strobed memory access of one slave model.
  task automatic serve_request(input int j);
    int w;
    w = int'(cap_addr[j][9:2]);
    sreq_cnt++;
    if (cap_addr[j][31:28] != 4'(j)) begin
      $display("ERROR %0t: slave %0d got address %h", $time, j, cap_addr[j]);
      errors++;
    end
    srdata[j] = 32'h0;
    if (cap_write[j]) begin
      for (int k = 0; k < 4; k++) begin
        if (cap_strb[j][k]) smem[j][w][8*k +: 8] = cap_wdata[j][8*k +: 8];
      end
    end else begin
      srdata[j] = smem[j][w];
    end
  endtask

  initial begin
    void'($urandom(32'h1f53));
    arst_n = 1'b0;
    mst_req_valid = '0;
    mst_req_write = '0;
    mst_rsp_ready = '0;
    slv_req_ready = '0;
    slv_rsp_valid = '0;
    for (int i = 0; i < 2; i++) begin
      mst_req_addr[i] = '0;
      mst_req_wdata[i] = '0;
      mst_req_strb[i] = '0;
      slv_rsp_rdata[i] = '0;
      slv_rsp_resp[i] = lite_xbar_pkg::RESP_OKAY;
      mstate[i] = 0;
      sstate[i] = 0;
      // Each word starts out holding its own byte address.
      for (int w = 0; w < 256; w++) smem[i][w] = {4'(i), 18'd0, 8'(w), 2'b00};
    end
    for (int i = 0; i < MAX_LINES * COLS; i++) vec[i] = '1;
    $readmemh("verif/lite_xbar_input.txt", vec);
    nlines = 0;
    mapped = 0;
    while (nlines < MAX_LINES && vec[nlines*COLS] != 32'hffffffff) begin
      mst_q[vec[nlines*COLS][0]].push_back(nlines);
      if (vec[nlines*COLS+2][31:28] < 4'd2) mapped++;
      nlines++;
    end
    limit = 200 * nlines;
    repeat (2) @(posedge clk);
    #1 arst_n = 1'b1;

    while (done_cnt < nlines) begin
      // Sample handshakes mid-cycle where all signals are settled.
      @(negedge clk);
      for (int i = 0; i < 2; i++) begin
        mreq_x[i] = mst_req_valid[i] && mst_req_ready[i];
        mrsp_x[i] = mst_rsp_valid[i] && mst_rsp_ready[i];
        cap_rdata[i] = mst_rsp_rdata[i];
        cap_resp[i] = mst_rsp_resp[i];
        sreq_x[i] = slv_req_valid[i] && slv_req_ready[i];
        srsp_x[i] = slv_rsp_valid[i] && slv_rsp_ready[i];
        cap_addr[i] = slv_req_addr[i];
        cap_wdata[i] = slv_req_wdata[i];
        cap_strb[i] = slv_req_strb[i];
        cap_write[i] = slv_req_write[i];
      end
      @(posedge clk);
      #1;
      for (int m = 0; m < 2; m++) begin
        if (mrsp_x[m]) begin
          if (mstate[m] != 2) begin
            $display("master %0d received a response it did not ask for", m);
            errors++;
          end else begin
            check_response(m);
            done_cnt++;
            mstate[m] = 0;
          end
        end
        if (mreq_x[m]) begin
          mst_req_valid[m] = 1'b0;
          mstate[m] = 2;
        end
        if (mstate[m] == 0 && mst_q[m].size() > 0) begin
          cur[m] = mst_q[m].pop_front();
          mst_req_write[m] = vec[cur[m]*COLS+1][0];
          mst_req_addr[m] = vec[cur[m]*COLS+2];
          mst_req_wdata[m] = vec[cur[m]*COLS+3];
          mst_req_strb[m] = vec[cur[m]*COLS+4][3:0];
          mst_req_valid[m] = 1'b1;
          mstate[m] = 1;
        end
        mst_rsp_ready[m] = ($urandom % 3) != 0;
      end
      for (int j = 0; j < 2; j++) begin
        if (srsp_x[j]) begin
          slv_rsp_valid[j] = 1'b0;
          sstate[j] = 0;
        end
        if (sreq_x[j]) begin
          serve_request(j);
          sdelay[j] = int'($urandom % 4);
          sstate[j] = 1;
        end
        if (sstate[j] == 1) begin
          if (sdelay[j] == 0) begin
            slv_rsp_valid[j] = 1'b1;
            slv_rsp_rdata[j] = srdata[j];
            slv_rsp_resp[j] = lite_xbar_pkg::RESP_OKAY;
            sstate[j] = 2;
          end else begin
            sdelay[j]--;
          end
        end
        slv_req_ready[j] = (sstate[j] == 0) && ($urandom % 2 == 1);
      end
    end

    // Unmapped requests must never show up at a slave port.
    if (sreq_cnt != mapped) begin
      $display("slave ports saw %0d requests, %0d were mapped", sreq_cnt, mapped);
      errors++;
    end
    $display("tests %0d, passed %0d, failed %0d, errors %0d", nlines, passed, failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    wait (arst_n === 1'b1);
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d of %0d tests done", cycles, done_cnt, nlines);
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/lite_addr_decode.sv
/*
 * Input side of one master port. Decodes the target slave from the address
 * region and offers mapped requests to that slave's multiplexer. Unmapped
 * requests are answered here with a decode error. Only one request per
 * master is in flight; the busy flag holds off the next one until the
 * response has reached the master.
 */
`timescale 1ns/10ps
`default_nettype none

`include "lite_xbar_macros.svh"

module lite_addr_decode (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    req_valid,
  output logic                    req_ready,
  input  lite_xbar_pkg::req_t     req,
  output logic                    fwd_valid,
  input  logic                    fwd_ready,
  output lite_xbar_pkg::slv_idx_t fwd_idx,
  output logic                    err_valid,
  input  logic                    err_ready,
  input  logic                    rsp_done
);

  localparam int REGION_W = `LITE_ADDR_W - `LITE_SLV_SHIFT;

  logic [REGION_W-1:0]     region;
  logic                    mapped;
  logic                    busy;
  lite_xbar_pkg::slv_idx_t idx_q;

  assign region = req.addr[`LITE_SLV_SHIFT +: REGION_W];
  assign mapped = region < REGION_W'(`LITE_NUM_SLV);

  // While busy the held index keeps the response router on the owned slave.
  assign fwd_idx = busy ? idx_q : lite_xbar_pkg::slv_idx_t'(region);

  assign fwd_valid = req_valid && !busy && mapped;
  // Error response goes out in the accept cycle, straight to the router.
  assign err_valid = req_valid && !busy && !mapped;
  assign req_ready = !busy && (mapped ? fwd_ready : err_ready);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy  <= 1'b0;
      idx_q <= '0;
    end else begin
      if (req_valid && req_ready) begin
        busy  <= 1'b1;
        idx_q <= lite_xbar_pkg::slv_idx_t'(region);
      end else if (rsp_done) begin
        busy <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/lite_resp_route.sv
/*
 * Output side of one master port. Passes either the response of the slave
 * this master is waiting on or the local decode error, and returns ready
 * only to the chosen source. Purely combinational.
 */
`timescale 1ns/10ps
`default_nettype none

`include "lite_xbar_macros.svh"

module lite_resp_route (
  input  logic                     sel_err,
  input  lite_xbar_pkg::slv_idx_t  sel_slv,
  input  logic [`LITE_NUM_SLV-1:0] slv_valid,
  output logic [`LITE_NUM_SLV-1:0] slv_ready,
  input  lite_xbar_pkg::rsp_t      slv_rsp [`LITE_NUM_SLV],
  input  logic                     err_valid,
  output logic                     err_ready,
  output logic                     out_valid,
  input  logic                     out_ready,
  output lite_xbar_pkg::rsp_t      out_rsp
);

  always_comb begin
    slv_ready = '0;
    if (sel_err) begin
      out_valid = err_valid;
      out_rsp   = '{data: '0, resp: lite_xbar_pkg::RESP_DECERR};
      err_ready = out_ready;
    end else begin
      // slv_valid is already masked to slaves owned by this master.
      out_valid          = slv_valid[sel_slv];
      out_rsp            = slv_rsp[sel_slv];
      err_ready          = 1'b0;
      slv_ready[sel_slv] = out_ready;
    end
  end

endmodule

`default_nettype wire

// File: verilog/lite_slave_mux.sv
/*
 * Processing part in front of one slave port. A round-robin arbiter picks one
 * of the masters that target this slave. The winner stays owner until the
 * slave response has been taken, so the response routers can follow it.
 */
`timescale 1ns/10ps
`default_nettype none

`include "lite_xbar_macros.svh"

module lite_slave_mux (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [`LITE_NUM_MST-1:0] in_valid,
  output logic [`LITE_NUM_MST-1:0] in_ready,
  input  lite_xbar_pkg::req_t      in_req [`LITE_NUM_MST],
  output logic                     out_valid,
  input  logic                     out_ready,
  output lite_xbar_pkg::req_t      out_req,
  input  logic                     rsp_done,
  output lite_xbar_pkg::slv_idx_t  owner
);

  localparam int NM = `LITE_NUM_MST;

  logic                    locked;
  logic                    sent;
  logic                    any_valid;
  lite_xbar_pkg::slv_idx_t owner_q;
  lite_xbar_pkg::slv_idx_t prio;
  lite_xbar_pkg::slv_idx_t arb_idx;
  lite_xbar_pkg::slv_idx_t sel;

  // Search from prio upward. Walk the offsets backwards so the nearest wins.
  always_comb begin : arbitrate
    int unsigned cand;
    arb_idx   = prio;
    any_valid = 1'b0;
    for (int k = NM - 1; k >= 0; k--) begin
      cand = (int'(prio) + k) % NM;
      if (in_valid[cand]) begin
        arb_idx   = lite_xbar_pkg::slv_idx_t'(cand);
        any_valid = 1'b1;
      end
    end
  end

  assign sel   = locked ? owner_q : arb_idx;
  assign owner = sel;

  // Nothing more is offered once the owner's request has gone out.
  assign out_valid = !sent && in_valid[sel];
  assign out_req   = in_req[sel];

  always_comb begin
    for (int m = 0; m < NM; m++) begin
      in_ready[m] = !sent && out_ready && (sel == lite_xbar_pkg::slv_idx_t'(m));
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      locked  <= 1'b0;
      sent    <= 1'b0;
      owner_q <= '0;
      prio    <= '0;
    end else begin
      // Lock on the first offered beat so the grant holds under back-pressure.
      if (!locked && any_valid) begin
        locked  <= 1'b1;
        owner_q <= arb_idx;
      end
      if (out_valid && out_ready) begin
        sent <= 1'b1;
      end
      if (rsp_done) begin
        locked <= 1'b0;
        sent   <= 1'b0;
        prio   <= (owner_q == lite_xbar_pkg::slv_idx_t'(NM - 1)) ? '0 : owner_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/lite_slice.sv
/*
 * One-entry valid/ready register slice. The payload type is a parameter, so
 * the same slice sits on slave request ports and master response ports.
 * A new beat is taken in the cycle the held beat leaves.
 */
`timescale 1ns/10ps
`default_nettype none

module lite_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // The entry is free when empty or when it drains this cycle.
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/lite_xbar.sv
/*
 * Top level of the lite crossbar, two masters by two slaves. A decoder,
 * response router and response slice sit on each master port; an arbitrating
 * multiplexer and request slice sit on each slave port.
 */
`timescale 1ns/10ps
`default_nettype none

`include "lite_xbar_macros.svh"

module lite_xbar (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [`LITE_NUM_MST-1:0] mst_req_valid,
  output logic [`LITE_NUM_MST-1:0] mst_req_ready,
  input  logic [`LITE_ADDR_W-1:0]  mst_req_addr  [`LITE_NUM_MST],
  input  logic [`LITE_NUM_MST-1:0] mst_req_write,
  input  logic [`LITE_DATA_W-1:0]  mst_req_wdata [`LITE_NUM_MST],
  input  logic [`LITE_STRB_W-1:0]  mst_req_strb  [`LITE_NUM_MST],
  output logic [`LITE_NUM_MST-1:0] mst_rsp_valid,
  input  logic [`LITE_NUM_MST-1:0] mst_rsp_ready,
  output logic [`LITE_DATA_W-1:0]  mst_rsp_rdata [`LITE_NUM_MST],
  output lite_xbar_pkg::resp_e     mst_rsp_resp  [`LITE_NUM_MST],
  output logic [`LITE_NUM_SLV-1:0] slv_req_valid,
  input  logic [`LITE_NUM_SLV-1:0] slv_req_ready,
  output logic [`LITE_ADDR_W-1:0]  slv_req_addr  [`LITE_NUM_SLV],
  output logic [`LITE_NUM_SLV-1:0] slv_req_write,
  output logic [`LITE_DATA_W-1:0]  slv_req_wdata [`LITE_NUM_SLV],
  output logic [`LITE_STRB_W-1:0]  slv_req_strb  [`LITE_NUM_SLV],
  input  logic [`LITE_NUM_SLV-1:0] slv_rsp_valid,
  output logic [`LITE_NUM_SLV-1:0] slv_rsp_ready,
  input  logic [`LITE_DATA_W-1:0]  slv_rsp_rdata [`LITE_NUM_SLV],
  input  lite_xbar_pkg::resp_e     slv_rsp_resp  [`LITE_NUM_SLV]
);

  localparam int NM = `LITE_NUM_MST;
  localparam int NS = `LITE_NUM_SLV;

  lite_xbar_pkg::req_t     mst_req     [NM];
  lite_xbar_pkg::rsp_t     mst_rsp     [NM];
  lite_xbar_pkg::rsp_t     rt_rsp      [NM];
  lite_xbar_pkg::slv_idx_t dec_fwd_idx [NM];
  logic [NM-1:0]           dec_fwd_valid;
  logic [NM-1:0]           dec_fwd_ready;
  logic [NM-1:0]           dec_err_valid;
  logic [NM-1:0]           dec_err_ready;
  logic [NM-1:0]           rt_valid;
  logic [NM-1:0]           rt_ready;
  logic [NM-1:0]           mst_done;
  logic [NS-1:0]           rt_slv_valid [NM];
  logic [NS-1:0]           rt_slv_ready [NM];

  lite_xbar_pkg::req_t     slv_req     [NS];
  lite_xbar_pkg::rsp_t     slv_rsp     [NS];
  lite_xbar_pkg::req_t     mux_out_req [NS];
  lite_xbar_pkg::slv_idx_t mux_owner   [NS];
  logic [NM-1:0]           mux_in_valid [NS];
  logic [NM-1:0]           mux_in_ready [NS];
  logic [NS-1:0]           mux_out_valid;
  logic [NS-1:0]           mux_out_ready;
  logic [NS-1:0]           slv_done;

  for (genvar m = 0; m < NM; m++) begin : g_mst
    assign mst_req[m] = '{
      addr:  mst_req_addr[m],
      write: mst_req_write[m],
      data:  mst_req_wdata[m],
      strb:  mst_req_strb[m]
    };
    assign mst_done[m]      = mst_rsp_valid[m] && mst_rsp_ready[m];
    assign dec_fwd_ready[m] = mux_in_ready[dec_fwd_idx[m]][m];

    // Only responses of slaves owned by this master are visible to its router.
    for (genvar j = 0; j < NS; j++) begin : g_own
      assign rt_slv_valid[m][j] =
        slv_rsp_valid[j] && (mux_owner[j] == lite_xbar_pkg::slv_idx_t'(m));
    end

    lite_addr_decode u_dec (
      .clk       (clk),
      .arst_n    (arst_n),
      .req_valid (mst_req_valid[m]),
      .req_ready (mst_req_ready[m]),
      .req       (mst_req[m]),
      .fwd_valid (dec_fwd_valid[m]),
      .fwd_ready (dec_fwd_ready[m]),
      .fwd_idx   (dec_fwd_idx[m]),
      .err_valid (dec_err_valid[m]),
      .err_ready (dec_err_ready[m]),
      .rsp_done  (mst_done[m])
    );

    lite_resp_route u_route (
      .sel_err   (dec_err_valid[m]),
      .sel_slv   (dec_fwd_idx[m]),
      .slv_valid (rt_slv_valid[m]),
      .slv_ready (rt_slv_ready[m]),
      .slv_rsp   (slv_rsp),
      .err_valid (dec_err_valid[m]),
      .err_ready (dec_err_ready[m]),
      .out_valid (rt_valid[m]),
      .out_ready (rt_ready[m]),
      .out_rsp   (rt_rsp[m])
    );

    lite_slice #(
      .payload_t (lite_xbar_pkg::rsp_t)
    ) u_rsp_slice (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (rt_valid[m]),
      .in_ready  (rt_ready[m]),
      .in_data   (rt_rsp[m]),
      .out_valid (mst_rsp_valid[m]),
      .out_ready (mst_rsp_ready[m]),
      .out_data  (mst_rsp[m])
    );

    assign mst_rsp_rdata[m] = mst_rsp[m].data;
    assign mst_rsp_resp[m]  = mst_rsp[m].resp;
  end

  for (genvar j = 0; j < NS; j++) begin : g_slv
    for (genvar m = 0; m < NM; m++) begin : g_req
      assign mux_in_valid[j][m] =
        dec_fwd_valid[m] && (dec_fwd_idx[m] == lite_xbar_pkg::slv_idx_t'(j));
    end

    assign slv_rsp[j]       = '{data: slv_rsp_rdata[j], resp: slv_rsp_resp[j]};
    assign slv_done[j]      = slv_rsp_valid[j] && slv_rsp_ready[j];
    assign slv_rsp_ready[j] = rt_slv_ready[mux_owner[j]][j];

    lite_slave_mux u_mux (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (mux_in_valid[j]),
      .in_ready  (mux_in_ready[j]),
      .in_req    (mst_req),
      .out_valid (mux_out_valid[j]),
      .out_ready (mux_out_ready[j]),
      .out_req   (mux_out_req[j]),
      .rsp_done  (slv_done[j]),
      .owner     (mux_owner[j])
    );

    lite_slice #(
      .payload_t (lite_xbar_pkg::req_t)
    ) u_req_slice (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (mux_out_valid[j]),
      .in_ready  (mux_out_ready[j]),
      .in_data   (mux_out_req[j]),
      .out_valid (slv_req_valid[j]),
      .out_ready (slv_req_ready[j]),
      .out_data  (slv_req[j])
    );

    assign slv_req_addr[j]  = slv_req[j].addr;
    assign slv_req_write[j] = slv_req[j].write;
    assign slv_req_wdata[j] = slv_req[j].data;
    assign slv_req_strb[j]  = slv_req[j].strb;
  end

endmodule

`default_nettype wire

// File: verilog/lite_xbar_pkg.sv
/*
 * Types shared by the lite crossbar RTL. Request and response beats are
 * packed structs, so one register slice carries either of them.
 */
`default_nettype none

`include "lite_xbar_macros.svh"

package lite_xbar_pkg;

  // Response code returned with every beat on the response channel.
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_DECERR = 2'b11
  } resp_e;

  // Selects one slave port. Also sized to hold a master index.
  typedef logic [$clog2(`LITE_NUM_SLV)-1:0] slv_idx_t;

  typedef struct packed {
    logic [`LITE_ADDR_W-1:0] addr;
    logic                    write;
    logic [`LITE_DATA_W-1:0] data;
    logic [`LITE_STRB_W-1:0] strb;
  } req_t;

  typedef struct packed {
    logic [`LITE_DATA_W-1:0] data;
    resp_e                   resp;
  } rsp_t;

endpackage

`default_nettype wire
